//--- sources.f
+incdir+rtl
+incdir+bench
rtl/har_pkg.sv
rtl/argmax.sv
rtl/hidden_projection.sv
rtl/class_scorer.sv
rtl/vote_smoother.sv
rtl/har_top.sv
bench/tb_har.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal -j 0
TOP      := tb_har
FILELIST := sources.f
BUILD    := obj_dir
LOG      := sim.log
PASS_MSG := All tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o V$(TOP)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation PASSED"; \
	else \
		echo "Simulation FAILED"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

//--- bench/har_model.svh
`ifndef HAR_MODEL_SVH
`define HAR_MODEL_SVH

`include "har_cfg.svh"

typedef har_pkg::class_t class_q_t [$];

// Positive set adds, negative set subtracts; a non-negative total gives a 1
function automatic har_pkg::hid_vec_t model_project(input har_pkg::feat_vec_t f);
    har_pkg::hid_vec_t h;
    int                diff;
    int                val;
    for (int j = 0; j < `HAR_N_HID; j++) begin
        diff = 0;
        for (int i = 0; i < `HAR_N_FEAT; i++) begin
            val = f[(`HAR_N_FEAT-i)*`HAR_FEAT_W-1 -: `HAR_FEAT_W];  // Feature 0 at the top
            diff += har_pkg::PROJ_POS_MASK[j][i] ? val : -val;
        end
        h[j] = (diff >= 0);
    end
    return h;
endfunction

// Score each class by signature agreement and keep the first maximum
function automatic har_pkg::class_t model_classify(input har_pkg::hid_vec_t h);
    int              score;
    int              best_score;
    har_pkg::class_t best;
    best_score = -1;
    best       = '0;
    for (int c = 0; c < `HAR_N_CLASS; c++) begin
        score = 0;
        for (int j = 0; j < `HAR_N_HID; j++) begin
            if (h[j] == har_pkg::CLASS_SIGNATURE[c][j])
                score++;
        end
        if (score > best_score) begin
            best_score = score;
            best       = har_pkg::class_t'(c);
        end
    end
    return best;
endfunction

// Majority over whatever the history holds with the lowest class winning a tie
function automatic har_pkg::class_t model_vote(input class_q_t hist);
    int              cnt [`HAR_N_CLASS];
    har_pkg::class_t best;
    foreach (cnt[c])
        cnt[c] = 0;
    foreach (hist[k])
        cnt[hist[k]]++;
    best = '0;
    for (int c = 1; c < `HAR_N_CLASS; c++) begin
        if (cnt[c] > cnt[best])
            best = har_pkg::class_t'(c);
    end
    return best;
endfunction

`endif

//--- bench/tb_har.sv
`timescale 1ns/1ps
`include "har_cfg.svh"

module tb_har;

    `include "har_model.svh"

    logic               clk = 1'b0;
    logic               rst_n;
    logic               in_valid;
    har_pkg::feat_vec_t features;
    logic               raw_valid;
    har_pkg::class_t    raw_class;
    logic               smooth_valid;
    har_pkg::class_t    smooth_class;
    logic               window_full;

    int              cyc = 0;
    int              due_q [$];   // Cycle in which each pending raw result is due
    har_pkg::class_t cls_q [$];
    class_q_t        hist;        // Newest decision first
    logic            smooth_due = 1'b0;
    har_pkg::class_t smooth_exp;
    int              sent;

    har_top dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .features     (features),
        .raw_valid    (raw_valid),
        .raw_class    (raw_class),
        .smooth_valid (smooth_valid),
        .smooth_class (smooth_class),
        .window_full  (window_full)
    );

    always #20 clk = ~clk;

    task automatic stop_run();
        $display("Some tests failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic fail_value(input string name, input logic [7:0] exp, input logic [7:0] act);
        $display("CHECK FAILED at %0d ns: %s expected %0d, got %0d", $time, name, exp, act);
        stop_run();
    endtask

    task automatic fail_other(input string what);
        $display("ERROR at %0d ns: %s", $time, what);
        stop_run();
    endtask

    function automatic har_pkg::feat_vec_t random_sample();
        logic [63:0] r;
        r = {$urandom(), $urandom()};
        return r[$bits(har_pkg::feat_vec_t)-1:0];
    endfunction

    // Outputs settled at the last rising edge, so the falling edge is a safe place to look
    task automatic check_outputs();
        logic exp_raw;
        logic exp_full;
        if (rst_n === 1'b1) begin
            exp_raw  = (due_q.size() > 0 && due_q[0] == cyc);
            exp_full = (hist.size() >= `HAR_VOTE_WIN);
            assert (window_full === exp_full)
                else fail_value("window_full", 8'(exp_full), 8'(window_full));
            assert (smooth_valid === smooth_due)
                else fail_value("smooth_valid", 8'(smooth_due), 8'(smooth_valid));
            if (smooth_due) begin
                assert (smooth_class === smooth_exp)
                    else fail_value("smooth_class", 8'(smooth_exp), 8'(smooth_class));
            end
            assert (raw_valid === exp_raw)
                else fail_value("raw_valid", 8'(exp_raw), 8'(raw_valid));
            smooth_due = exp_raw;
            if (exp_raw) begin
                assert (raw_class === cls_q[0])
                    else fail_value("raw_class", 8'(cls_q[0]), 8'(raw_class));
                hist.push_front(cls_q[0]);
                if (hist.size() > `HAR_VOTE_WIN)
                    void'(hist.pop_back());
                smooth_exp = model_vote(hist);
                void'(due_q.pop_front());
                void'(cls_q.pop_front());
            end
        end
    endtask

    task automatic tick(input logic v, input har_pkg::feat_vec_t f);
        @(negedge clk);
        cyc++;
        check_outputs();
        in_valid = v;
        features = f;
        if (v) begin
            due_q.push_back(cyc + 2);
            cls_q.push_back(model_classify(model_project(f)));
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (due_q.size() > 0 || smooth_due) begin
            if (waited == 20) begin
                fail_other("timed out waiting for raw_valid or smooth_valid");
            end else begin
                tick(1'b0, features);
                waited++;
            end
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        cyc++;
        check_outputs();
        rst_n    = 1'b0;
        in_valid = 1'b0;
        due_q.delete();
        cls_q.delete();
        hist.delete();      // The DUT history empties as well
        smooth_due = 1'b0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
    endtask

    initial begin
        void'($urandom(96591));
        rst_n    = 1'b0;
        in_valid = 1'b0;
        features = '0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        repeat (4) tick(1'b0, '0);

        sent = 0;
        while (sent < 300) begin
            if ($urandom_range(3) != 0) begin  // Mostly back to back
                tick(1'b1, random_sample());
                sent++;
            end else begin
                tick(1'b0, features);
            end
        end
        drain();

        // All-zero makes every sum equal; all-15 hits the same edge for balanced masks
        tick(1'b1, '0);
        tick(1'b1, '1);
        tick(1'b0, '0);
        tick(1'b1, '1);
        drain();

        apply_reset();
        repeat (4) begin
            tick(1'b1, random_sample());
            tick(1'b0, features);
        end
        drain();
        assert (window_full === 1'b0) else fail_value("window_full", 8'd0, 8'(window_full));
        tick(1'b1, random_sample());
        drain();
        assert (window_full === 1'b1) else fail_value("window_full", 8'd1, 8'(window_full));

        $display("All tests passed");
        $finish;
    end

endmodule

//--- rtl/har_top.sv
`timescale 1ns/1ps

module har_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    input  har_pkg::feat_vec_t features,
    output logic               raw_valid,
    output har_pkg::class_t    raw_class,
    output logic               smooth_valid,
    output har_pkg::class_t    smooth_class,
    output logic               window_full
);

    logic              hid_valid;
    har_pkg::hid_vec_t hid_bits;

    hidden_projection u_hidden_projection (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .features  (features),
        .hid_valid (hid_valid),
        .hid_bits  (hid_bits)
    );

    // Per-class scores stay inside the scorer
    class_scorer u_class_scorer (
        .clk        (clk),
        .rst_n      (rst_n),
        .hid_valid  (hid_valid),
        .hid_bits   (hid_bits),
        .raw_valid  (raw_valid),
        .raw_class  (raw_class),
        .raw_scores ()
    );

    vote_smoother u_vote_smoother (
        .clk          (clk),
        .rst_n        (rst_n),
        .raw_valid    (raw_valid),
        .raw_class    (raw_class),
        .smooth_valid (smooth_valid),
        .smooth_class (smooth_class),
        .window_full  (window_full)
    );

endmodule

//--- rtl/vote_smoother.sv
`timescale 1ns/1ps
`include "har_cfg.svh"

module vote_smoother (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            raw_valid,
    input  har_pkg::class_t raw_class,
    output logic            smooth_valid,
    output har_pkg::class_t smooth_class,
    output logic            window_full
);

    localparam int CNT_W = $clog2(`HAR_VOTE_WIN + 1);

    har_pkg::class_t              hist_class [0:`HAR_VOTE_WIN-1];  // Entry 0 is the newest
    logic [`HAR_VOTE_WIN-1:0]     hist_occ;
    har_pkg::class_t              next_class [0:`HAR_VOTE_WIN-1];
    logic [`HAR_VOTE_WIN-1:0]     next_occ;
    har_pkg::class_t              vote_class;
    logic                         vote_seen;

    // History as it will look once the incoming decision is shifted in
    always_comb begin
        next_class[0] = raw_class;
        next_occ[0]   = 1'b1;
        for (int k = 1; k < `HAR_VOTE_WIN; k++) begin
            next_class[k] = hist_class[k-1];
            next_occ[k]   = hist_occ[k-1];
        end
    end

    always_comb begin
        logic [CNT_W-1:0] count;
        logic [CNT_W-1:0] best_count;
        best_count = '0;
        vote_class = '0;
        for (int c = 0; c < `HAR_N_CLASS; c++) begin
            count = '0;
            for (int k = 0; k < `HAR_VOTE_WIN; k++) begin
                if (next_occ[k] && next_class[k] == har_pkg::class_t'(c))
                    count = count + 1'b1;
            end
            if (count > best_count) begin  // Lowest class keeps a tie
                best_count = count;
                vote_class = har_pkg::class_t'(c);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hist_occ     <= '0;
            smooth_valid <= 1'b0;
        end else begin
            smooth_valid <= raw_valid;
            if (raw_valid)
                hist_occ <= next_occ;
        end
    end

    always_ff @(posedge clk) begin
        if (raw_valid) begin
            hist_class   <= next_class;
            smooth_class <= vote_class;
        end
    end

    assign window_full = &hist_occ;  // Flags only fill up until the next reset

    // The smoothed class must be held by at least one occupied entry
    always_comb begin
        vote_seen = 1'b0;
        for (int k = 0; k < `HAR_VOTE_WIN; k++) begin
            if (hist_occ[k] && hist_class[k] == smooth_class)
                vote_seen = 1'b1;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) smooth_valid == $past(raw_valid))
        else $error("smooth_valid does not follow raw_valid by one cycle");
    assert property (@(posedge clk) disable iff (!rst_n) smooth_valid |-> vote_seen)
        else $error("smooth_class %0d not found in the history", smooth_class);

endmodule

//--- rtl/class_scorer.sv
`timescale 1ns/1ps
`include "har_cfg.svh"

module class_scorer (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                hid_valid,
    input  har_pkg::hid_vec_t   hid_bits,
    output logic                raw_valid,
    output har_pkg::class_t     raw_class,
    output har_pkg::score_vec_t raw_scores
);

    har_pkg::score_vec_t scores;
    har_pkg::class_t     best_class;

    // A hidden bit agrees with a class when it matches the signature bit
    always_comb begin
        for (int c = 0; c < `HAR_N_CLASS; c++) begin
            scores[c] = har_pkg::score_t'($countones(~(hid_bits ^ har_pkg::CLASS_SIGNATURE[c])));
        end
    end

    argmax #(
        .N_IN    (`HAR_N_CLASS),
        .SCORE_W ($bits(har_pkg::score_t))
    ) u_argmax (
        .scores    (scores),
        .max_index (best_class)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            raw_valid <= 1'b0;
        end else begin
            raw_valid <= hid_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (hid_valid) begin
            raw_scores <= scores;
            raw_class  <= best_class;
        end
    end

    // No class agrees on more bits than there are projections or beats the registered winner
    for (genvar c = 0; c < `HAR_N_CLASS; c++) begin : g_score_chk
        assert property (@(posedge clk) disable iff (!rst_n)
            raw_valid |-> raw_scores[c] <= har_pkg::score_t'(`HAR_N_HID)
                          && raw_scores[c] <= raw_scores[raw_class])
            else $error("class %0d score %0d above limit or above the winner", c, raw_scores[c]);
    end

endmodule

//--- rtl/hidden_projection.sv
`timescale 1ns/1ps
`include "har_cfg.svh"

module hidden_projection (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    input  har_pkg::feat_vec_t features,
    output logic               hid_valid,
    output har_pkg::hid_vec_t  hid_bits
);

    har_pkg::hid_vec_t proj_bits;

    always_comb begin
        har_pkg::proj_sum_t     pos_sum;
        har_pkg::proj_sum_t     neg_sum;
        logic [`HAR_FEAT_W-1:0] feat;
        for (int j = 0; j < `HAR_N_HID; j++) begin
            pos_sum = '0;
            neg_sum = '0;
            for (int i = 0; i < `HAR_N_FEAT; i++) begin
                feat = features[(`HAR_N_FEAT-1-i)*`HAR_FEAT_W +: `HAR_FEAT_W];
                if (har_pkg::PROJ_POS_MASK[j][i])
                    pos_sum = pos_sum + har_pkg::proj_sum_t'(feat);
                else
                    neg_sum = neg_sum + har_pkg::proj_sum_t'(feat);
            end
            proj_bits[j] = (pos_sum >= neg_sum);  // Equal sums give a 1
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hid_valid <= 1'b0;
        end else begin
            hid_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            hid_bits <= proj_bits;
        end
    end

    // Downstream stages qualify everything on this strobe
    assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(hid_valid))
        else $error("hid_valid unknown");

endmodule

//--- rtl/argmax.sv
`timescale 1ns/1ps

module argmax #(
    parameter int N_IN    = 6,
    parameter int SCORE_W = 6
) (
    input  logic [N_IN*SCORE_W-1:0]   scores,
    output logic [$clog2(N_IN)-1:0]   max_index
);

    localparam int IDX_W = $clog2(N_IN);

    always_comb begin
        logic [SCORE_W-1:0] best_score;
        logic [SCORE_W-1:0] win_score;
        logic               first_max;
        best_score = scores[SCORE_W-1:0];
        max_index  = '0;
        // Strictly greater keeps the first maximum, so ties go to the lower index
        for (int i = 1; i < N_IN; i++) begin
            if (scores[i*SCORE_W +: SCORE_W] > best_score) begin
                best_score = scores[i*SCORE_W +: SCORE_W];
                max_index  = IDX_W'(i);
            end
        end

        // The index must name a real candidate that no lower index ties and no higher index beats
        first_max = (int'(max_index) < N_IN);
        win_score = '0;
        if (first_max)
            win_score = scores[int'(max_index)*SCORE_W +: SCORE_W];
        for (int i = 0; i < N_IN; i++) begin
            if (i < int'(max_index) && scores[i*SCORE_W +: SCORE_W] >= win_score)
                first_max = 1'b0;
            if (i > int'(max_index) && scores[i*SCORE_W +: SCORE_W] > win_score)
                first_max = 1'b0;
        end
        assert (first_max)
            else $error("argmax index %0d is not the first maximum", max_index);
    end

endmodule

//--- rtl/har_pkg.sv
`include "har_cfg.svh"

package har_pkg;

    // Feature 0 sits in the most significant nibble
    typedef logic [`HAR_N_FEAT*`HAR_FEAT_W-1:0] feat_vec_t;

    typedef logic [`HAR_N_HID-1:0] hid_vec_t;   // Bit j is projection j

    typedef logic [7:0] proj_sum_t;             // Holds 12 x 15

    typedef logic [5:0] score_t;                // 0 to 40 agreeing bits

    typedef score_t [`HAR_N_CLASS-1:0] score_vec_t;  // Class 0 in the lowest field

    typedef logic [2:0] class_t;

    // Bit i set puts feature i in the positive set, clear puts it in the negative set
    localparam logic [`HAR_N_FEAT-1:0] PROJ_POS_MASK [0:`HAR_N_HID-1] = '{
        12'hA39, 12'hE61, 12'h60D, 12'h024,     // 0 to 3
        12'h305, 12'h382, 12'hE31, 12'hE16,     // 4 to 7
        12'hEF8, 12'hD55, 12'hD44, 12'h68C,     // 8 to 11
        12'h195, 12'h12F, 12'h0C0, 12'hE3C,     // 12 to 15
        12'h5F4, 12'h2EB, 12'h1B7, 12'h349,     // 16 to 19
        12'h9E6, 12'hEE8, 12'h0F3, 12'hA3C,     // 20 to 23
        12'h67A, 12'h9CE, 12'hC3F, 12'h901,     // 24 to 27
        12'h181, 12'hBAD, 12'hD01, 12'h107,     // 28 to 31
        12'h985, 12'h4F5, 12'hA6A, 12'hE71,     // 32 to 35
        12'hAF2, 12'hC72, 12'h32D, 12'h4D9      // 36 to 39
    };

    // A set bit means the class scores a point when that hidden bit is 1,
    // a clear bit means it scores when the hidden bit is 0
    localparam hid_vec_t CLASS_SIGNATURE [0:`HAR_N_CLASS-1] = '{
        40'h72_4509_C3C4,
        40'h7F_6031_8FC1,
        40'h54_66AD_CB4D,
        40'hE7_DE35_C22A,
        40'hD6_FCA5_5A74,
        40'hE7_D82F_9628
    };

endpackage

//--- rtl/har_cfg.svh
`ifndef HAR_CFG_SVH
`define HAR_CFG_SVH

// Features per sample and the bits in each
`define HAR_N_FEAT 12
`define HAR_FEAT_W 4

`define HAR_N_HID 40    // Signed projections, one hidden bit each

`define HAR_N_CLASS 6

// Raw decisions kept for the majority vote
`define HAR_VOTE_WIN 5

`endif
